//--- include/tile_defines.svh
// Tile memory subsystem sizing and address map macros
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// L1 scratchpad geometry, word interleaved across banks
`define TILE_N_BANKS     4
`define TILE_WORDS_BANK  64

// Data path width in bits, byte enables follow as TILE_DW/8
`define TILE_DW          32

// L1 window, 1 KiB = banks x words x 4 bytes
// Both bounds are inclusive
`define TILE_L1_START    32'h1000_0000
`define TILE_L1_END      32'h1000_03FF

// External L2 window, inclusive
`define TILE_L2_START    32'h8000_0000
`define TILE_L2_END      32'h8FFF_FFFF

// Max L2 transactions in flight from the core port
`define TILE_MAX_TRAN    4

`endif

//--- hw/tile_pkg.sv
// Tile package with the bank, word, count and power state types
`default_nettype none

`include "tile_defines.svh"

package tile_pkg;

  // Bank select, taken from the address just above the byte offset
  typedef logic [$clog2(`TILE_N_BANKS)-1:0] bank_idx_t;

  // Word inside one bank, next address bits above the bank select
  typedef logic [$clog2(`TILE_WORDS_BANK)-1:0] word_idx_t;

  // In-flight count, must reach TILE_MAX_TRAN itself
  typedef logic [$clog2(`TILE_MAX_TRAN+1)-1:0] out_cnt_t;

  // Tile power sequencing
  typedef enum logic [1:0] {
    OFF   = 2'd0,  // No new requests accepted
    RUN   = 2'd1,  // Normal operation
    DRAIN = 2'd2   // Disabled, waiting for responses to return
  } power_state_t;

endpackage

`default_nettype wire

//--- hw/mem_port_if.sv
// OBI-style memory port with request, grant and response channel
`timescale 1ns/1ns
`default_nettype none

`include "tile_defines.svh"

interface mem_port_if;

  logic                  req;    // Request, held until granted
  logic                  gnt;    // Grant, same cycle as accepted req
  logic [31:0]           addr;   // Byte address
  logic                  we;     // Write enable
  logic [`TILE_DW/8-1:0] be;     // Byte enables
  logic [`TILE_DW-1:0]   wdata;  // Write data
  logic                  rvalid; // One response per grant, in order
  logic [`TILE_DW-1:0]   rdata;  // Read data
  logic                  err;    // Error response

  // Requester side
  modport mgr (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  // Memory side
  modport sub (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

//--- hw/outstanding_counter.sv
// Up/down counter of transactions in flight with zero and full flags
`timescale 1ns/1ns
`default_nettype none

module outstanding_counter #(
  parameter int unsigned MAX = 4  // Must fit tile_pkg::out_cnt_t
) (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic inc_i,   // Transaction granted
  input  logic dec_i,   // Response returned
  output logic zero_o,
  output logic full_o
);

  tile_pkg::out_cnt_t cnt_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (inc_i && !dec_i && !full_o) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (dec_i && !inc_i && !zero_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
    // Both at once leave the count as is
  end

  assign zero_o = (cnt_q == '0);
  assign full_o = (cnt_q == tile_pkg::out_cnt_t'(MAX));

endmodule

`default_nettype wire

//--- hw/tile_power_fsm.sv
// Tile enable sequencer, drains core traffic before switching the tile off
`timescale 1ns/1ns
`default_nettype none

module tile_power_fsm (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic tile_enable_i,  // External enable request
  input  logic idle_i,         // No core transaction outstanding
  output logic accept_en_o,    // New requests may be granted
  output logic busy_o          // Tile on or still draining
);

  tile_pkg::power_state_t state_q, state_d;

  always_comb begin
    state_d = state_q;  // Hold by default
    case (state_q)
      tile_pkg::OFF: begin
        if (tile_enable_i) state_d = tile_pkg::RUN;  // Registered enable
      end
      tile_pkg::RUN: begin
        if (!tile_enable_i) state_d = tile_pkg::DRAIN;  // Stop accepting first
      end
      tile_pkg::DRAIN: begin
        // Leave only once every granted request has its response
        if (idle_i) state_d = tile_pkg::OFF;
      end
      default: state_d = tile_pkg::OFF;  // Unused encoding
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= tile_pkg::OFF;
    end else begin
      state_q <= state_d;
    end
  end

  // Only RUN accepts, DRAIN lets responses finish
  assign accept_en_o = (state_q == tile_pkg::RUN);
  assign busy_o      = (state_q != tile_pkg::OFF);

endmodule

`default_nettype wire

//--- hw/obi_target_demux.sv
// Core data demux routing to L1, L2 or an error reply with in-order responses
`timescale 1ns/1ns
`default_nettype none

`include "tile_defines.svh"

module obi_target_demux (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  accept_en_i,
  input  logic                  core_req_i,
  output logic                  core_gnt_o,
  input  logic [31:0]           core_addr_i,
  input  logic                  core_we_i,
  input  logic [`TILE_DW/8-1:0] core_be_i,
  input  logic [`TILE_DW-1:0]   core_wdata_i,
  output logic                  core_rvalid_o,
  output logic [`TILE_DW-1:0]   core_rdata_o,
  output logic                  core_err_o,
  output logic                  l2_req_o,
  input  logic                  l2_gnt_i,
  output logic [31:0]           l2_addr_o,
  output logic                  l2_we_o,
  output logic [`TILE_DW/8-1:0] l2_be_o,
  output logic [`TILE_DW-1:0]   l2_wdata_o,
  input  logic                  l2_rvalid_i,
  input  logic [`TILE_DW-1:0]   l2_rdata_i,
  input  logic                  l2_err_i,
  mem_port_if.mgr               l1_o,
  output logic                  idle_o
);

  typedef enum logic [1:0] {TGT_L1, TGT_L2, TGT_ERR} target_e;

  target_e tgt, last_tgt_q;   // Current decode, target of last grant
  logic    l1_pend_q;         // L1 reply due this cycle
  logic    err_pend_q;        // Error reply due this cycle
  logic    l2_zero, l2_full;  // L2 in-flight flags
  logic    in_flight;
  logic    allow;             // Ordering and enable check passed
  logic    gnt_fire;

  always_comb begin
    if (core_addr_i >= `TILE_L1_START && core_addr_i <= `TILE_L1_END) begin
      tgt = TGT_L1;
    end else if (core_addr_i >= `TILE_L2_START && core_addr_i <= `TILE_L2_END) begin
      tgt = TGT_L2;
    end else begin
      tgt = TGT_ERR;  // Unmapped
    end
  end

  assign in_flight = l1_pend_q | err_pend_q | ~l2_zero;
  assign idle_o    = ~in_flight;

  // Switching target only when drained keeps replies in grant order
  assign allow = accept_en_i & (~in_flight | (tgt == last_tgt_q))
                 & ~((tgt == TGT_L2) & l2_full);

  assign l1_o.req   = core_req_i & allow & (tgt == TGT_L1);
  assign l1_o.addr  = core_addr_i;
  assign l1_o.we    = core_we_i;
  assign l1_o.be    = core_be_i;
  assign l1_o.wdata = core_wdata_i;

  assign l2_req_o   = core_req_i & allow & (tgt == TGT_L2);  // Combinational pass
  assign l2_addr_o  = core_addr_i;
  assign l2_we_o    = core_we_i;
  assign l2_be_o    = core_be_i;
  assign l2_wdata_o = core_wdata_i;

  always_comb begin
    case (tgt)
      TGT_L1:  core_gnt_o = l1_o.gnt;              // Bank arbitration result
      TGT_L2:  core_gnt_o = l2_req_o & l2_gnt_i;
      default: core_gnt_o = core_req_i & allow;    // Error path takes it at once
    endcase
  end

  assign gnt_fire = core_req_i & core_gnt_o;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      l1_pend_q  <= 1'b0;
      err_pend_q <= 1'b0;
      last_tgt_q <= TGT_L1;
    end else begin
      l1_pend_q  <= gnt_fire & (tgt == TGT_L1);
      err_pend_q <= gnt_fire & (tgt == TGT_ERR);
      if (gnt_fire) last_tgt_q <= tgt;
    end
  end

  outstanding_counter #(
    .MAX (`TILE_MAX_TRAN)
  ) u_l2_cnt (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .inc_i  (l2_req_o & l2_gnt_i),
    .dec_i  (l2_rvalid_i),
    .zero_o (l2_zero),
    .full_o (l2_full)
  );

  // At most one source replies in a cycle, ordering rule guarantees it
  assign core_rvalid_o = l1_o.rvalid | l2_rvalid_i | err_pend_q;
  assign core_rdata_o  = l1_o.rvalid ? l1_o.rdata :
                         l2_rvalid_i ? l2_rdata_i : '0;  // Zero on error reply
  assign core_err_o    = err_pend_q | (l2_rvalid_i & l2_err_i) | (l1_o.rvalid & l1_o.err);

endmodule

`default_nettype wire

//--- hw/l1_spm.sv
// L1 scratchpad banks, byte-enable writes and one-cycle registered reads
`timescale 1ns/1ns
`default_nettype none

`include "tile_defines.svh"

module l1_spm (
  input  logic                                      clk_i,
  input  logic [`TILE_N_BANKS-1:0]                  bank_req_i,
  input  logic [`TILE_N_BANKS-1:0]                  bank_we_i,
  input  logic [`TILE_N_BANKS-1:0][`TILE_DW/8-1:0]  bank_be_i,
  input  tile_pkg::word_idx_t [`TILE_N_BANKS-1:0]   bank_word_i,
  input  logic [`TILE_N_BANKS-1:0][`TILE_DW-1:0]    bank_wdata_i,
  output logic [`TILE_N_BANKS-1:0][`TILE_DW-1:0]    bank_rdata_o
);

  for (genvar b = 0; b < `TILE_N_BANKS; b++) begin : g_bank
    logic [`TILE_DW-1:0] mem_q [`TILE_WORDS_BANK];  // Bank storage
    logic [`TILE_DW-1:0] rdata_q;                   // Read port register

    always_ff @(posedge clk_i) begin
      if (bank_req_i[b]) begin
        if (bank_we_i[b]) begin
          for (int i = 0; i < `TILE_DW/8; i++) begin
            if (bank_be_i[b][i]) begin
              mem_q[bank_word_i[b]][8*i +: 8] <= bank_wdata_i[b][8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem_q[bank_word_i[b]];  // Valid the cycle after the grant
        end
      end
    end

    assign bank_rdata_o[b] = rdata_q;
  end

endmodule

`default_nettype wire

//--- hw/l1_interconnect.sv
// L1 bank interconnect with per-bank round-robin between core and accelerator
`timescale 1ns/1ns
`default_nettype none

`include "tile_defines.svh"

module l1_interconnect (
  input  logic    clk_i,
  input  logic    rstn_i,
  input  logic    accept_en_i,  // Gates new grants on both ports
  mem_port_if.sub core_i,
  mem_port_if.sub acc_i
);

  localparam int unsigned NB = `TILE_N_BANKS;
  localparam int unsigned BW = $bits(tile_pkg::bank_idx_t);
  localparam int unsigned WW = $bits(tile_pkg::word_idx_t);

  tile_pkg::bank_idx_t                   core_bank, acc_bank;      // Decoded bank
  tile_pkg::bank_idx_t                   core_bank_q, acc_bank_q;  // Response tags
  tile_pkg::word_idx_t                   core_word, acc_word;
  logic [NB-1:0]                         core_hit, acc_hit;
  logic [NB-1:0]                         core_win, acc_win;
  logic [NB-1:0]                         prio_q;                   // 1 favours accelerator
  logic                                  core_rvalid_q, acc_rvalid_q;
  logic [NB-1:0]                         bank_req, bank_we;
  logic [NB-1:0][`TILE_DW/8-1:0]         bank_be;
  tile_pkg::word_idx_t [NB-1:0]          bank_word;
  logic [NB-1:0][`TILE_DW-1:0]           bank_wdata, bank_rdata;

  assign core_bank = core_i.addr[2 +: BW];  // Word interleaved
  assign acc_bank  = acc_i.addr[2 +: BW];
  assign core_word = core_i.addr[2+BW +: WW];
  assign acc_word  = acc_i.addr[2+BW +: WW];

  always_comb begin
    for (int b = 0; b < NB; b++) begin
      core_hit[b] = core_i.req & accept_en_i & (core_bank == tile_pkg::bank_idx_t'(b));
      acc_hit[b]  = acc_i.req & accept_en_i & (acc_bank == tile_pkg::bank_idx_t'(b));
      core_win[b] = core_hit[b] & (~acc_hit[b] | ~prio_q[b]);
      acc_win[b]  = acc_hit[b] & (~core_hit[b] | prio_q[b]);
      // Bank payload from whichever port won
      bank_req[b]   = core_win[b] | acc_win[b];
      bank_we[b]    = acc_win[b] ? acc_i.we    : core_i.we;
      bank_be[b]    = acc_win[b] ? acc_i.be    : core_i.be;
      bank_word[b]  = acc_win[b] ? acc_word    : core_word;
      bank_wdata[b] = acc_win[b] ? acc_i.wdata : core_i.wdata;
    end
  end

  assign core_i.gnt = |core_win;
  assign acc_i.gnt  = |acc_win;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      prio_q        <= '0;
      core_rvalid_q <= 1'b0;
      acc_rvalid_q  <= 1'b0;
    end else begin
      prio_q        <= prio_q ^ (core_hit & acc_hit);  // Flip on conflict only
      core_rvalid_q <= core_i.gnt;
      acc_rvalid_q  <= acc_i.gnt;
    end
  end

  // Bank of each granted access, steers read data next cycle
  always_ff @(posedge clk_i) begin
    if (core_i.gnt) core_bank_q <= core_bank;
    if (acc_i.gnt) acc_bank_q <= acc_bank;
  end

  assign core_i.rvalid = core_rvalid_q;
  assign core_i.rdata  = bank_rdata[core_bank_q];
  assign core_i.err    = 1'b0;  // L1 never faults
  assign acc_i.rvalid  = acc_rvalid_q;
  assign acc_i.rdata   = bank_rdata[acc_bank_q];
  assign acc_i.err     = 1'b0;

  l1_spm u_spm (
    .clk_i        (clk_i),
    .bank_req_i   (bank_req),
    .bank_we_i    (bank_we),
    .bank_be_i    (bank_be),
    .bank_word_i  (bank_word),
    .bank_wdata_i (bank_wdata),
    .bank_rdata_o (bank_rdata)
  );

endmodule

`default_nettype wire

//--- hw/tile_top.sv
// Tile top level joining the power sequencer, core data demux and shared L1
`timescale 1ns/1ns
`default_nettype none

`include "tile_defines.svh"

module tile_top (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  tile_enable_i,
  output logic                  busy_o,
  // Core data port
  input  logic                  core_req_i,
  output logic                  core_gnt_o,
  input  logic [31:0]           core_addr_i,
  input  logic                  core_we_i,
  input  logic [`TILE_DW/8-1:0] core_be_i,
  input  logic [`TILE_DW-1:0]   core_wdata_i,
  output logic                  core_rvalid_o,
  output logic [`TILE_DW-1:0]   core_rdata_o,
  output logic                  core_err_o,
  // Accelerator data port, L1 only
  input  logic                  acc_req_i,
  output logic                  acc_gnt_o,
  input  logic [31:0]           acc_addr_i,
  input  logic                  acc_we_i,
  input  logic [`TILE_DW/8-1:0] acc_be_i,
  input  logic [`TILE_DW-1:0]   acc_wdata_i,
  output logic                  acc_rvalid_o,
  output logic [`TILE_DW-1:0]   acc_rdata_o,
  // External L2 port
  output logic                  l2_req_o,
  input  logic                  l2_gnt_i,
  output logic [31:0]           l2_addr_o,
  output logic                  l2_we_o,
  output logic [`TILE_DW/8-1:0] l2_be_o,
  output logic [`TILE_DW-1:0]   l2_wdata_o,
  input  logic                  l2_rvalid_i,
  input  logic [`TILE_DW-1:0]   l2_rdata_i,
  input  logic                  l2_err_i
);

  logic accept_en;  // From sequencer, opens the request paths
  logic idle;       // Nothing in flight on the core path

  mem_port_if core_l1 ();  // Demux to L1
  mem_port_if acc_l1 ();   // Accelerator to L1

  // Accelerator pins onto its L1 port
  assign acc_l1.req    = acc_req_i;
  assign acc_l1.addr   = acc_addr_i;
  assign acc_l1.we     = acc_we_i;
  assign acc_l1.be     = acc_be_i;
  assign acc_l1.wdata  = acc_wdata_i;
  assign acc_gnt_o     = acc_l1.gnt;
  assign acc_rvalid_o  = acc_l1.rvalid;
  assign acc_rdata_o   = acc_l1.rdata;

  tile_power_fsm u_power_fsm (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .tile_enable_i (tile_enable_i),
    .idle_i        (idle),
    .accept_en_o   (accept_en),
    .busy_o        (busy_o)
  );

  obi_target_demux u_demux (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .accept_en_i   (accept_en),
    .core_req_i    (core_req_i),
    .core_gnt_o    (core_gnt_o),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .core_err_o    (core_err_o),
    .l2_req_o      (l2_req_o),
    .l2_gnt_i      (l2_gnt_i),
    .l2_addr_o     (l2_addr_o),
    .l2_we_o       (l2_we_o),
    .l2_be_o       (l2_be_o),
    .l2_wdata_o    (l2_wdata_o),
    .l2_rvalid_i   (l2_rvalid_i),
    .l2_rdata_i    (l2_rdata_i),
    .l2_err_i      (l2_err_i),
    .l1_o          (core_l1.mgr),
    .idle_o        (idle)
  );

  l1_interconnect u_l1 (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .accept_en_i (accept_en),
    .core_i      (core_l1.sub),
    .acc_i       (acc_l1.sub)
  );

endmodule

`default_nettype wire

//--- sim/tile_clkgen.sv
// Testbench clock and reset source, 20 ns period and reset held 8 cycles
`timescale 1ns/1ns
`default_nettype none

module tile_clkgen #(
  parameter int unsigned HALF_NS    = 10,  // Half period
  parameter int unsigned RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the sampling edge
    rstn_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/tile_chk.sv
// Bound checker on tile ports for response, enable and accelerator timing rules
`timescale 1ns/1ns
`default_nettype none

module tile_chk (
  input logic clk_i,
  input logic rstn_i,
  input logic tile_enable_i,
  input logic core_req_i,
  input logic core_gnt_i,
  input logic core_rvalid_i,
  input logic acc_gnt_i,
  input logic acc_rvalid_i,
  input logic l2_req_i
);

  logic [3:0] pend_q;     // Core grants still owed a response
  logic       en_seen_q;  // Enable seen high since reset

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      pend_q    <= '0;
      en_seen_q <= 1'b0;
    end else begin
      pend_q <= pend_q + 4'(core_req_i & core_gnt_i) - 4'(core_rvalid_i);
      if (tile_enable_i) en_seen_q <= 1'b1;
    end
  end

  core_rsp_granted: assert property (@(posedge clk_i) disable iff (!rstn_i)
    core_rvalid_i |-> (pend_q != 4'd0))
    else $error("core response with no grant before it");

  // Tile never enabled, so nothing may reach L2
  l2_quiet_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !en_seen_q |-> !l2_req_i)
    else $error("L2 request while tile never enabled");

  acc_rsp_next: assert property (@(posedge clk_i) disable iff (!rstn_i)
    acc_gnt_i |=> acc_rvalid_i)
    else $error("accelerator response missing one cycle after grant");

  acc_rsp_only: assert property (@(posedge clk_i) disable iff (!rstn_i)
    acc_rvalid_i |-> $past(acc_gnt_i))
    else $error("accelerator response without grant the cycle before");

endmodule

bind tile_top tile_chk u_chk (
  .clk_i         (clk_i),
  .rstn_i        (rstn_i),
  .tile_enable_i (tile_enable_i),
  .core_req_i    (core_req_i),
  .core_gnt_i    (core_gnt_o),
  .core_rvalid_i (core_rvalid_o),
  .acc_gnt_i     (acc_gnt_o),
  .acc_rvalid_i  (acc_rvalid_o),
  .l2_req_i      (l2_req_o)
);

`default_nettype wire

//--- sim/tile_tb.sv
// Directed testbench for the tile memory subsystem with an in-order L2 responder
`timescale 1ns/1ns
`default_nettype none

`include "tile_defines.svh"

module tile_tb;

  localparam int TMO      = 60;  // Cycle limit for each wait
  localparam int L1_WORDS = `TILE_N_BANKS * `TILE_WORDS_BANK;
  localparam int IW       = $clog2(L1_WORDS);

  typedef struct packed {
    logic                chk;   // Compare rdata
    logic                err;
    logic [`TILE_DW-1:0] data;
  } rsp_t;

  logic                  clk, rstn, tile_enable, busy;
  logic                  core_req, core_gnt, core_we, core_rvalid, core_err;
  logic [31:0]           core_addr;
  logic [`TILE_DW/8-1:0] core_be;
  logic [`TILE_DW-1:0]   core_wdata, core_rdata;
  logic                  acc_req, acc_gnt, acc_we, acc_rvalid;
  logic [31:0]           acc_addr;
  logic [`TILE_DW/8-1:0] acc_be;
  logic [`TILE_DW-1:0]   acc_wdata, acc_rdata;
  logic                  l2_req, l2_gnt, l2_we, l2_rvalid, l2_err;
  logic [31:0]           l2_addr;
  logic [`TILE_DW/8-1:0] l2_be;
  logic [`TILE_DW-1:0]   l2_wdata, l2_rdata;

  int                    errors = 0;
  int                    checks = 0;
  integer                seed = 32'hd202;
  int unsigned           cyc = 0;                // Rising edges so far
  logic [`TILE_DW-1:0]   l1_model [L1_WORDS];    // Expected L1 contents
  rsp_t                  core_exp_q[$];
  rsp_t                  acc_exp_q[$];
  int unsigned           l2_due_q[$];            // Reply cycle per L2 grant
  logic [`TILE_DW-1:0]   l2_data_q[$];
  int unsigned           l2_last_due = 0;
  logic [31:0]           l2_seen_addr;           // Last request on the L2 port
  logic                  l2_seen_we;
  logic [`TILE_DW/8-1:0] l2_seen_be;
  logic [`TILE_DW-1:0]   l2_seen_wdata;

  tile_clkgen u_clkgen (.clk_o(clk), .rstn_o(rstn));

  tile_top dut0 (
    .clk_i (clk), .rstn_i (rstn), .tile_enable_i (tile_enable), .busy_o (busy),
    .core_req_i (core_req), .core_gnt_o (core_gnt), .core_addr_i (core_addr),
    .core_we_i (core_we), .core_be_i (core_be), .core_wdata_i (core_wdata),
    .core_rvalid_o (core_rvalid), .core_rdata_o (core_rdata), .core_err_o (core_err),
    .acc_req_i (acc_req), .acc_gnt_o (acc_gnt), .acc_addr_i (acc_addr),
    .acc_we_i (acc_we), .acc_be_i (acc_be), .acc_wdata_i (acc_wdata),
    .acc_rvalid_o (acc_rvalid), .acc_rdata_o (acc_rdata),
    .l2_req_o (l2_req), .l2_gnt_i (l2_gnt), .l2_addr_o (l2_addr), .l2_we_o (l2_we),
    .l2_be_o (l2_be), .l2_wdata_o (l2_wdata), .l2_rvalid_i (l2_rvalid),
    .l2_rdata_i (l2_rdata), .l2_err_i (l2_err)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  function automatic logic in_l1(input logic [31:0] addr);
    return addr >= `TILE_L1_START && addr <= `TILE_L1_END;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w, input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];  // Byte lane enabled
    end
    return res;
  endfunction

  function automatic rsp_t expected_core_rsp(input logic [31:0] addr, input logic we);
    rsp_t r;
    r.chk  = ~we;  // Write replies carry no data
    r.err  = 1'b0;
    r.data = '0;
    if (in_l1(addr)) begin
      r.data = l1_model[addr[2 +: IW]];
    end else if (addr >= `TILE_L2_START && addr <= `TILE_L2_END) begin
      r.data = addr ^ 32'hA5A5_A5A5;  // Responder pattern
    end else begin
      r.chk = 1'b1;  // Unmapped reply has zero data
      r.err = 1'b1;
    end
    return r;
  endfunction

  task automatic core_issue(input logic [31:0] addr, input logic we,
                            input logic [3:0] be, input logic [31:0] wdata);
    int n;
    core_req   = 1'b1;
    core_addr  = addr;
    core_we    = we;
    core_be    = be;
    core_wdata = wdata;
    n = 0;
    @(negedge clk);
    while (!core_gnt && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (core_gnt) begin
      core_exp_q.push_back(expected_core_rsp(addr, we));
      if (we && in_l1(addr)) begin
        l1_model[addr[2 +: IW]] = merge_bytes(l1_model[addr[2 +: IW]], wdata, be);
      end
    end else begin
      errors++;
      $display("Timeout at %0t ns: core request to %h was never granted", $time, addr);
    end
    @(posedge clk);
    #2;
    core_req = 1'b0;
  endtask

  task automatic acc_issue(input logic [31:0] addr, input logic we,
                           input logic [3:0] be, input logic [31:0] wdata);
    int   n;
    rsp_t r;
    acc_req   = 1'b1;
    acc_addr  = addr;
    acc_we    = we;
    acc_be    = be;
    acc_wdata = wdata;
    n = 0;
    @(negedge clk);
    while (!acc_gnt && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (acc_gnt) begin
      r.chk  = ~we;
      r.err  = 1'b0;
      r.data = l1_model[addr[2 +: IW]];
      acc_exp_q.push_back(r);
      if (we) l1_model[addr[2 +: IW]] = merge_bytes(l1_model[addr[2 +: IW]], wdata, be);
    end else begin
      errors++;
      $display("Timeout at %0t ns: accelerator request to %h was never granted", $time, addr);
    end
    @(posedge clk);
    #2;
    acc_req = 1'b0;
  endtask

  task automatic drain_responses();
    int n;
    n = 0;
    while ((core_exp_q.size() != 0 || acc_exp_q.size() != 0) && n < TMO) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (core_exp_q.size() != 0 || acc_exp_q.size() != 0) begin
      errors++;
      $display("Timeout at %0t ns: responses still missing", $time);
    end
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (busy !== level && n < TMO) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (busy !== level) begin
      errors++;
      $display("Timeout at %0t ns: busy_o never reached %b", $time, level);
    end
  endtask

  // L1 writes with partial byte enables then read back of all eight words
  task automatic l1_readback();
    for (int i = 0; i < 8; i++) core_issue(`TILE_L1_START + 32'(4*i), 1'b1, 4'hF, $random(seed));
    core_issue(`TILE_L1_START + 32'h04, 1'b1, 4'b0011, 32'hDEAD_BEEF);
    core_issue(`TILE_L1_START + 32'h10, 1'b1, 4'b1100, 32'hCAFE_F00D);
    core_issue(`TILE_L1_START + 32'h1C, 1'b1, 4'b0100, 32'h0055_0000);
    for (int i = 0; i < 8; i++) core_issue(`TILE_L1_START + 32'(4*i), 1'b0, 4'hF, '0);
    drain_responses();
  endtask

  // Accelerator block read by the core then same-bank conflicts
  task automatic shared_bank_access();
    for (int i = 0; i < 4; i++) begin
      acc_issue(`TILE_L1_START + 32'h40 + 32'(4*i), 1'b1, 4'hF, $random(seed));
    end
    drain_responses();
    for (int i = 0; i < 4; i++) core_issue(`TILE_L1_START + 32'h40 + 32'(4*i), 1'b0, 4'hF, '0);
    drain_responses();
    repeat (2) begin
      fork  // Both hit bank 1 in the same cycle
        core_issue(`TILE_L1_START + 32'h44, 1'b0, 4'hF, '0);
        acc_issue(`TILE_L1_START + 32'h14, 1'b0, 4'hF, '0);
      join
    end
    drain_responses();
  endtask

  // L2 request payload passes through unchanged
  task automatic l2_passthrough();
    core_issue(32'h8000_0100, 1'b1, 4'b0110, 32'h1234_5678);
    compare_value("l2_addr_o", l2_seen_addr, 32'h8000_0100);
    compare_value("l2_we_o", 32'(l2_seen_we), 32'd1);
    compare_value("l2_be_o", 32'(l2_seen_be), 32'h6);
    compare_value("l2_wdata_o", l2_seen_wdata, 32'h1234_5678);
    core_issue(32'h8000_0100, 1'b0, 4'hF, '0);
    compare_value("l2_we_o", 32'(l2_seen_we), 32'd0);
    drain_responses();
  endtask

  // L2 reads then an L1 read come back in issue order
  task automatic response_order();
    for (int i = 0; i < 3; i++) core_issue(32'h8000_0200 + 32'(4*i), 1'b0, 4'hF, '0);
    core_issue(`TILE_L1_START, 1'b0, 4'hF, '0);
    drain_responses();
  endtask

  // Unmapped accesses answer with err and zero data
  task automatic unmapped_access();
    core_issue(32'h4000_0000, 1'b0, 4'hF, '0);
    core_issue(`TILE_L1_END + 32'd1, 1'b1, 4'hF, 32'hFFFF_FFFF);  // Just past L1
    drain_responses();
  endtask

  // Requests held while disabled complete after enabling
  task automatic enable_hold();
    tile_enable = 1'b0;
    wait_busy(1'b0);
    core_req   = 1'b1;  // L2 read held before the tile was ever enabled
    core_addr  = 32'h8000_0300;
    core_we    = 1'b0;
    core_be    = 4'hF;
    core_wdata = '0;
    acc_req    = 1'b1;
    acc_addr   = `TILE_L1_START + 32'h48;
    acc_we     = 1'b1;
    acc_be     = 4'hF;
    acc_wdata  = 32'h0BAD_F00D;
    repeat (20) begin
      @(negedge clk);
      if (core_gnt || acc_gnt || l2_req) begin
        errors++;
        $display("Grant or L2 request at %0t ns while the tile is disabled", $time);
      end
    end
    compare_value("busy_o", 32'(busy), 32'd0);
    @(posedge clk);
    #2;
    tile_enable = 1'b1;
    fork
      core_issue(32'h8000_0300, 1'b0, 4'hF, '0);
      acc_issue(`TILE_L1_START + 32'h48, 1'b1, 4'hF, 32'h0BAD_F00D);
    join
    compare_value("busy_o", 32'(busy), 32'd1);
    drain_responses();
  endtask

  initial begin : core_monitor
    rsp_t want;
    forever begin
      @(negedge clk);
      if (rstn && core_rvalid) begin
        if (core_exp_q.size() == 0) begin
          errors++;
          $display("Unexpected core response at %0t ns", $time);
        end else begin
          want = core_exp_q.pop_front();
          compare_value("core_err_o", 32'(core_err), 32'(want.err));
          if (want.chk) compare_value("core_rdata_o", core_rdata, want.data);
        end
      end
    end
  end

  initial begin : acc_monitor
    rsp_t want;
    forever begin
      @(negedge clk);
      if (rstn && acc_rvalid) begin
        if (acc_exp_q.size() == 0) begin
          errors++;
          $display("Unexpected accelerator response at %0t ns", $time);
        end else begin
          want = acc_exp_q.pop_front();
          if (want.chk) compare_value("acc_rdata_o", acc_rdata, want.data);
        end
      end
    end
  end

  // L2 responder takes requests at once and replies 1 to 4 cycles later in order
  initial begin : l2_accept
    int unsigned due;
    forever begin
      @(negedge clk);
      if (l2_req && l2_gnt) begin
        due = cyc + 1 + ({$random(seed)} % 4);
        if (due <= l2_last_due) due = l2_last_due + 1;  // Keep grant order
        l2_last_due = due;
        l2_due_q.push_back(due);
        l2_data_q.push_back(l2_addr ^ 32'hA5A5_A5A5);
        l2_seen_addr  = l2_addr;
        l2_seen_we    = l2_we;
        l2_seen_be    = l2_be;
        l2_seen_wdata = l2_wdata;
      end
    end
  end

  initial begin : l2_reply
    l2_gnt    = 1'b1;
    l2_err    = 1'b0;
    l2_rvalid = 1'b0;
    l2_rdata  = '0;
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      #2;
      if (l2_due_q.size() != 0 && l2_due_q[0] == cyc) begin
        l2_rvalid = 1'b1;
        l2_rdata  = l2_data_q.pop_front();
        void'(l2_due_q.pop_front());
      end else begin
        l2_rvalid = 1'b0;
        l2_rdata  = '0;
      end
    end
  end

  initial begin : main
    int n;
    tile_enable = 1'b0;
    core_req    = 1'b0;
    core_addr   = '0;
    core_we     = 1'b0;
    core_be     = '0;
    core_wdata  = '0;
    acc_req     = 1'b0;
    acc_addr    = '0;
    acc_we      = 1'b0;
    acc_be      = 4'hF;
    acc_wdata   = '0;
    n = 0;
    while (!rstn && n < TMO) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!rstn) begin
      errors++;
      $display("Timeout at %0t ns: reset was never released", $time);
    end
    compare_value("busy_o", 32'(busy), 32'd0);  // OFF after reset
    enable_hold();
    l1_readback();
    shared_bank_access();
    l2_passthrough();
    response_order();
    unmapped_access();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
hw/tile_pkg.sv
hw/mem_port_if.sv
hw/outstanding_counter.sv
hw/tile_power_fsm.sv
hw/obi_target_demux.sv
hw/l1_spm.sv
hw/l1_interconnect.sv
hw/tile_top.sv
sim/tile_clkgen.sv
sim/tile_chk.sv
sim/tile_tb.sv

//--- Makefile
# Verilator build and run of the tile memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= tile_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
